// File: common/ntm_cosh_config.svh
// Width, fraction and series length macros for the cosh datapath

`ifndef NTM_COSH_CONFIG_SVH
`define NTM_COSH_CONFIG_SVH

//////////////////////////////////////////////////
// Datapath format
//////////////////////////////////////////////////

// Signed Q16.16 element
`define NTM_DATA_WIDTH 32
`define NTM_FRAC_BITS 16

// Row and column counts
`define NTM_INDEX_WIDTH 16

// Taylor terms summed, term 0 included
`define NTM_COSH_TERMS 6

`endif

// File: common/ntm_cosh_pkg.sv
// Data, index and size types plus state enums of the cosh matrix unit

`default_nettype none

`include "ntm_cosh_config.svh"

package ntm_cosh_pkg;

  //////////////////////////////////////////////////
  // Scalar and index types
  //////////////////////////////////////////////////

  // Q16.16 element value
  typedef logic signed [`NTM_DATA_WIDTH-1:0] ntm_data_t;

  // Row or column count, also used as an index
  typedef logic [`NTM_INDEX_WIDTH-1:0] ntm_index_t;

  // Matrix dimensions, sampled once per matrix
  typedef struct packed {
    ntm_index_t size_i;
    ntm_index_t size_j;
  } ntm_matrix_size_t;

  //////////////////////////////////////////////////
  // Controller states
  //////////////////////////////////////////////////

  typedef enum logic [1:0] {matrix_idle, matrix_input, matrix_wait_vector} ntm_matrix_state_t;

  typedef enum logic [1:0] {vector_idle, vector_feed, vector_compute} ntm_vector_state_t;

  typedef enum logic [2:0] {
    scalar_idle,
    scalar_square,
    scalar_mult_x2,
    scalar_mult_recip,
    scalar_done
  } ntm_scalar_state_t;

endpackage

`default_nettype wire

// File: logic/ntm_scalar_cosh.sv
// Iterative Q16.16 cosh Taylor series unit with one shared multiplier

`timescale 1ns/1ns
`default_nettype none

`include "ntm_cosh_config.svh"

module ntm_scalar_cosh
  import ntm_cosh_pkg::*;
(
  input  logic      CLK,
  input  logic      RST,
  input  logic      start,
  input  ntm_data_t data_in,
  output logic      ready,
  output ntm_data_t data_out
);

  //////////////////////////////////////////////////
  // Constants
  //////////////////////////////////////////////////

  localparam int term_w = $clog2(`NTM_COSH_TERMS);
  localparam ntm_data_t fixed_one = ntm_data_t'(1 << `NTM_FRAC_BITS);

  //////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////

  ntm_scalar_state_t state;

  // Term number of the series step in progress
  logic [term_w-1:0] term_k;

  // Operand, its square, running term and sum
  ntm_data_t x;
  ntm_data_t x2;
  ntm_data_t term;
  ntm_data_t acc;

  // Shared multiplier
  ntm_data_t mult_a;
  ntm_data_t mult_b;
  logic signed [2*`NTM_DATA_WIDTH-1:0] mult_full;
  ntm_data_t mult_scaled;
  ntm_data_t acc_next;

  // 1 / ((2k-1) * 2k) in Q16.16, entry k for term k
  ntm_data_t recip_table [1:`NTM_COSH_TERMS-1];

  //////////////////////////////////////////////////
  // Reciprocal table
  //////////////////////////////////////////////////

  for (genvar k = 1; k < `NTM_COSH_TERMS; k++) begin : g_recip
    localparam int den = (2*k - 1) * (2*k);
    assign recip_table[k] = ntm_data_t'((1 << `NTM_FRAC_BITS) / den);
  end

  //////////////////////////////////////////////////
  // Datapath
  //////////////////////////////////////////////////

  // Operand select per state, squaring by default
  always_comb begin
    mult_a = x;
    mult_b = x;
    case (state)
      scalar_mult_x2: begin
        mult_a = term;
        mult_b = x2;
      end
      scalar_mult_recip: begin
        mult_a = term;
        mult_b = recip_table[term_k];
      end
      default: ;
    endcase
  end

  // Full product, then back to Q16.16
  assign mult_full   = mult_a * mult_b;
  assign mult_scaled = mult_full[`NTM_FRAC_BITS +: `NTM_DATA_WIDTH];
  assign acc_next    = acc + mult_scaled;

  // Operand and series registers
  always_ff @(posedge CLK) begin
    case (state)
      scalar_idle: begin
        if (start) begin
          x <= data_in;
        end
      end
      scalar_square: begin
        x2   <= mult_scaled;
        term <= fixed_one;
        acc  <= fixed_one;
      end
      // Previous term times x squared
      scalar_mult_x2: term <= mult_scaled;
      // Scale by recip_k and add to the sum
      scalar_mult_recip: begin
        term <= mult_scaled;
        acc  <= acc_next;
      end
      default: ;
    endcase
  end

  //////////////////////////////////////////////////
  // Control
  //////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state    <= scalar_idle;
      term_k   <= '0;
      ready    <= 1'b0;
      data_out <= '0;
    end else begin
      ready <= 1'b0;
      case (state)
        scalar_idle: begin
          if (start) begin
            state <= scalar_square;
          end
        end
        scalar_square: begin
          term_k <= term_w'(1);
          state  <= scalar_mult_x2;
        end
        scalar_mult_x2: state <= scalar_mult_recip;
        scalar_mult_recip: begin
          if (term_k == term_w'(`NTM_COSH_TERMS - 1)) begin
            // Last term lands, result out now
            data_out <= acc_next;
            ready    <= 1'b1;
            state    <= scalar_done;
          end else begin
            term_k <= term_k + 1'b1;
            state  <= scalar_mult_x2;
          end
        end
        scalar_done: state <= scalar_idle;
        default: state <= scalar_idle;
      endcase
    end
  end

  // Vector controller must wait for the previous result
  assert property (@(posedge CLK) disable iff (RST) start |-> state == scalar_idle)
    else $error("scalar start while busy");

endmodule

`default_nettype wire

// File: logic/ntm_vector_cosh.sv
// Row controller feeding elements to the scalar cosh unit and counting columns

`timescale 1ns/1ns
`default_nettype none

module ntm_vector_cosh
  import ntm_cosh_pkg::*;
(
  input  logic       CLK,
  input  logic       RST,
  input  logic       start,
  input  ntm_index_t size_in,
  input  logic       data_in_enable,
  input  ntm_data_t  data_in,
  output logic       data_out_enable,
  output ntm_data_t  data_out,
  output logic       ready
);

  //////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////

  ntm_vector_state_t state;

  // Row length and current column
  ntm_index_t row_size;
  ntm_index_t col_index;

  // Element taken this cycle
  logic accept;

  // Scalar unit handshake
  logic      scalar_start;
  ntm_data_t scalar_in;
  logic      scalar_ready;
  ntm_data_t scalar_out;

  //////////////////////////////////////////////////
  // Input acceptance
  //////////////////////////////////////////////////

  // First element may come together with start
  assign accept = data_in_enable &&
                  ((state == vector_idle && start) || state == vector_feed);

  always_ff @(posedge CLK) begin
    if (accept) begin
      scalar_in <= data_in;
    end
  end

  //////////////////////////////////////////////////
  // Row FSM
  //////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state           <= vector_idle;
      row_size        <= '0;
      col_index       <= '0;
      scalar_start    <= 1'b0;
      data_out_enable <= 1'b0;
      data_out        <= '0;
      ready           <= 1'b0;
    end else begin
      // Single cycle pulses
      scalar_start    <= 1'b0;
      data_out_enable <= 1'b0;
      ready           <= 1'b0;
      case (state)
        vector_idle: begin
          if (start) begin
            row_size  <= size_in;
            col_index <= '0;
            state     <= accept ? vector_compute : vector_feed;
            scalar_start <= accept;
          end
        end
        vector_feed: begin
          if (accept) begin
            scalar_start <= 1'b1;
            state        <= vector_compute;
          end
        end
        vector_compute: begin
          if (scalar_ready) begin
            data_out        <= scalar_out;
            data_out_enable <= 1'b1;
            if (col_index == row_size - 1'b1) begin
              // Row complete
              ready <= 1'b1;
              state <= vector_idle;
            end else begin
              col_index <= col_index + 1'b1;
              state     <= vector_feed;
            end
          end
        end
        default: state <= vector_idle;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Scalar unit
  //////////////////////////////////////////////////

  ntm_scalar_cosh i_ntm_scalar_cosh (
    .CLK      (CLK),
    .RST      (RST),
    .start    (scalar_start),
    .data_in  (scalar_in),
    .ready    (scalar_ready),
    .data_out (scalar_out)
  );

  // Empty rows are not supported
  assert property (@(posedge CLK) disable iff (RST) start |-> size_in != '0)
    else $error("vector start with zero row length");

endmodule

`default_nettype wire

// File: matrix/ntm_matrix_cosh.sv
// Top level cosh matrix controller with row indexing and output framing

`timescale 1ns/1ns
`default_nettype none

module ntm_matrix_cosh
  import ntm_cosh_pkg::*;
(
  input  logic             CLK,
  input  logic             RST,
  input  logic             START,
  input  logic             DATA_IN_I_ENABLE,
  input  logic             DATA_IN_J_ENABLE,
  input  ntm_matrix_size_t SIZE_IN,
  input  ntm_data_t        DATA_IN,
  output logic             READY,
  output logic             DATA_OUT_I_ENABLE,
  output logic             DATA_OUT_J_ENABLE,
  output ntm_data_t        DATA_OUT
);

  //////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////

  ntm_matrix_state_t state;

  // Sizes held for the whole matrix
  ntm_matrix_size_t size_reg;

  // Current row, and whether its first element was taken
  ntm_index_t row_index;
  logic       row_active;

  // Strobe taken this cycle
  logic accept;

  // Vector controller side
  logic      vector_start;
  logic      vector_data_enable;
  ntm_data_t vector_data_in;
  logic      vector_data_out_enable;
  ntm_data_t vector_data_out;
  logic      vector_ready;

  //////////////////////////////////////////////////
  // Strobe decode
  //////////////////////////////////////////////////

  // Row opens only on I and J together
  // Strobes outside the input state are dropped
  assign accept = state == matrix_input && DATA_IN_J_ENABLE &&
                  (DATA_IN_I_ENABLE || row_active);

  assign vector_start       = accept && !row_active;
  assign vector_data_enable = accept;
  assign vector_data_in     = DATA_IN;

  //////////////////////////////////////////////////
  // Matrix FSM
  //////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state             <= matrix_idle;
      size_reg          <= '0;
      row_index         <= '0;
      row_active        <= 1'b0;
      READY             <= 1'b0;
      DATA_OUT_I_ENABLE <= 1'b0;
      DATA_OUT_J_ENABLE <= 1'b0;
      DATA_OUT          <= '0;
    end else begin
      // Output strobes are single cycle
      READY             <= 1'b0;
      DATA_OUT_I_ENABLE <= 1'b0;
      DATA_OUT_J_ENABLE <= 1'b0;
      case (state)
        matrix_idle: begin
          if (START) begin
            size_reg   <= SIZE_IN;
            row_index  <= '0;
            row_active <= 1'b0;
            state      <= matrix_input;
          end
        end
        matrix_input: begin
          if (accept) begin
            row_active <= 1'b1;
            state      <= matrix_wait_vector;
          end
        end
        matrix_wait_vector: begin
          if (vector_data_out_enable) begin
            DATA_OUT          <= vector_data_out;
            DATA_OUT_J_ENABLE <= 1'b1;
            state             <= matrix_input;
            if (vector_ready) begin
              // End of row
              row_active        <= 1'b0;
              DATA_OUT_I_ENABLE <= 1'b1;
              if (row_index == size_reg.size_i - 1'b1) begin
                // Last element of the matrix
                READY <= 1'b1;
                state <= matrix_idle;
              end else begin
                row_index <= row_index + 1'b1;
              end
            end
          end
        end
        default: state <= matrix_idle;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Vector controller
  //////////////////////////////////////////////////

  ntm_vector_cosh i_ntm_vector_cosh (
    .CLK             (CLK),
    .RST             (RST),
    .start           (vector_start),
    .size_in         (size_reg.size_j),
    .data_in_enable  (vector_data_enable),
    .data_in         (vector_data_in),
    .data_out_enable (vector_data_out_enable),
    .data_out        (vector_data_out),
    .ready           (vector_ready)
  );

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  // Row end from the vector controller always carries a result
  assert property (@(posedge CLK) disable iff (RST) vector_ready |-> vector_data_out_enable)
    else $error("vector row end without result");

  // One element in flight, so results arrive only while one is pending
  assert property (@(posedge CLK) disable iff (RST)
                   vector_data_out_enable |-> state == matrix_wait_vector)
    else $error("vector result while none pending");

endmodule

`default_nettype wire

// File: verification/ntm_cosh_clock_gen.sv
// Testbench clock of 4 ns period and a two cycle reset

`timescale 1ns/1ns
`default_nettype none

module ntm_cosh_clock_gen (
  output logic CLK,
  output logic RST
);

  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;
  end

  // Reset held for the first two rising edges
  initial begin
    RST = 1'b1;
    repeat (2) @(posedge CLK);
    #1 RST = 1'b0;
  end

endmodule

`default_nettype wire

// File: verification/ntm_cosh_tb.sv
// Golden-file driven testbench for the cosh matrix unit with watchdog and report

`timescale 1ns/1ns
`default_nettype none

`include "ntm_cosh_config.svh"

module ntm_cosh_tb
  import ntm_cosh_pkg::*;
;

  logic             CLK;
  logic             RST;
  logic             START;
  logic             DATA_IN_I_ENABLE;
  logic             DATA_IN_J_ENABLE;
  ntm_matrix_size_t SIZE_IN;
  ntm_data_t        DATA_IN;
  logic             READY;
  logic             DATA_OUT_I_ENABLE;
  logic             DATA_OUT_J_ENABLE;
  ntm_data_t        DATA_OUT;

  // Golden data with one entry per test and per element
  ntm_index_t test_size_i [$];
  ntm_index_t test_size_j [$];
  int         test_mode [$];
  int         test_first [$];
  ntm_data_t  elem_in [$];
  ntm_data_t  elem_exp [$];

  integer seed;
  int     error_count;
  int     check_count;
  int     result_count;
  int     row_end_count;
  int     ready_count;
  logic   loaded;

  ntm_cosh_clock_gen i_ntm_cosh_clock_gen (.CLK(CLK), .RST(RST));

  ntm_matrix_cosh i_ntm_matrix_cosh (
    .CLK               (CLK),
    .RST               (RST),
    .START             (START),
    .DATA_IN_I_ENABLE  (DATA_IN_I_ENABLE),
    .DATA_IN_J_ENABLE  (DATA_IN_J_ENABLE),
    .SIZE_IN           (SIZE_IN),
    .DATA_IN           (DATA_IN),
    .READY             (READY),
    .DATA_OUT_I_ENABLE (DATA_OUT_I_ENABLE),
    .DATA_OUT_J_ENABLE (DATA_OUT_J_ENABLE),
    .DATA_OUT          (DATA_OUT)
  );

  //////////////////////////////////////////////////
  // Output strobe counters
  //////////////////////////////////////////////////

  always @(negedge CLK) begin
    if (!RST) begin
      if (DATA_OUT_J_ENABLE) result_count++;
      if (DATA_OUT_I_ENABLE) row_end_count++;
      if (READY) ready_count++;
    end
  end

  // Inputs change 1 ns after the rising edge
  task automatic drive_slot();
    @(posedge CLK);
    #1;
  endtask

  task automatic load_golden();
    int         fd;
    int         code;
    string      line;
    ntm_index_t si;
    ntm_index_t sj;
    int         md;
    ntm_data_t  a;
    ntm_data_t  b;
    fd = $fopen("verification/ntm_cosh_golden.txt", "r");
    if (fd == 0) begin
      $display("Golden file could not be opened");
      error_count++;
      return;
    end
    while (!$feof(fd)) begin
      code = $fgets(line, fd);
      if (code > 2) begin
        // Tag letter first, then hex fields
        if (line.getc(0) == "T") begin
          code = $sscanf(line.substr(2, line.len() - 1), "%h %h %h", si, sj, md);
          test_size_i.push_back(si);
          test_size_j.push_back(sj);
          test_mode.push_back(md);
          test_first.push_back(elem_in.size());
        end else if (line.getc(0) == "E") begin
          code = $sscanf(line.substr(2, line.len() - 1), "%h %h", a, b);
          elem_in.push_back(a);
          elem_exp.push_back(b);
        end
      end
    end
    $fclose(fd);
  endtask

  //////////////////////////////////////////////////
  // One matrix from START to READY
  //////////////////////////////////////////////////

  task automatic run_test(input int t);
    int        n;
    int        first_idx;
    int        col;
    int        gap;
    int        waited;
    int        errors_before;
    int        results_before;
    int        rows_before;
    int        ready_before;
    logic      seen;
    ntm_data_t prev_in;
    ntm_data_t prev_out;
    ntm_data_t neg_in;
    n = int'(test_size_i[t]) * int'(test_size_j[t]);
    first_idx = test_first[t];
    errors_before = error_count;
    results_before = result_count;
    rows_before = row_end_count;
    ready_before = ready_count;
    prev_in = '0;
    prev_out = '0;
    // START and sizes together in this slot
    START = 1'b1;
    SIZE_IN.size_i = test_size_i[t];
    SIZE_IN.size_j = test_size_j[t];
    drive_slot();
    START = 1'b0;
    // Sizes are held inside the DUT from here on
    SIZE_IN = '0;
    for (int e = 0; e < n; e++) begin
      col = e % int'(test_size_j[t]);
      if (test_mode[t] == 1) begin
        gap = $random(seed) & 32'h3;
        repeat (gap) drive_slot();
      end
      drive_slot();
      DATA_IN = elem_in[first_idx + e];
      DATA_IN_I_ENABLE = (col == 0);
      DATA_IN_J_ENABLE = 1'b1;
      drive_slot();
      DATA_IN_I_ENABLE = 1'b0;
      DATA_IN_J_ENABLE = 1'b0;
      DATA_IN = ~elem_in[first_idx + e];
      waited = 0;
      seen = 1'b0;
      while (!seen && waited < 64) begin
        @(negedge CLK);
        if (DATA_OUT_J_ENABLE) begin
          seen = 1'b1;
        end else begin
          @(posedge CLK);
          #1;
          // Stray J strobes early in the wait must be dropped
          DATA_IN_J_ENABLE = (test_mode[t] == 1 && waited < 4) ? 1'($random(seed)) : 1'b0;
          waited++;
        end
      end
      DATA_IN_J_ENABLE = 1'b0;
      if (!seen) begin
        $display("Element %0d of test %0d produced no result within 64 cycles", e, t);
        error_count++;
        return;
      end
      check_count += 3;
      assert (DATA_OUT == elem_exp[first_idx + e]) else begin
        $display("ERROR DATA_OUT expected %h got %h", elem_exp[first_idx + e], DATA_OUT);
        error_count++;
      end
      assert (DATA_OUT_I_ENABLE == (col == int'(test_size_j[t]) - 1)) else begin
        $display("ERROR DATA_OUT_I_ENABLE expected %h got %h",
                 (col == int'(test_size_j[t]) - 1), DATA_OUT_I_ENABLE);
        error_count++;
      end
      assert (READY == (e == n - 1)) else begin
        $display("ERROR READY expected %h got %h", (e == n - 1), READY);
        error_count++;
      end
      // Even function, so a negated input repeats the last result
      neg_in = -prev_in;
      if (e > 0 && elem_in[first_idx + e] == neg_in && neg_in != '0) begin
        check_count++;
        assert (DATA_OUT == prev_out) else begin
          $display("ERROR DATA_OUT symmetry expected %h got %h", prev_out, DATA_OUT);
          error_count++;
        end
      end
      prev_in = elem_in[first_idx + e];
      prev_out = DATA_OUT;
    end
    drive_slot();
    check_count += 3;
    assert (result_count - results_before == n) else begin
      $display("Test %0d gave %0d results instead of %0d", t,
               result_count - results_before, n);
      error_count++;
    end
    assert (row_end_count - rows_before == int'(test_size_i[t])) else begin
      $display("Test %0d gave %0d row ends instead of %0d", t,
               row_end_count - rows_before, test_size_i[t]);
      error_count++;
    end
    assert (ready_count - ready_before == 1) else begin
      $display("Test %0d gave %0d READY pulses instead of one", t, ready_count - ready_before);
      error_count++;
    end
    $display("test %0d size %0dx%0d mode %0d: %s", t, test_size_i[t], test_size_j[t],
             test_mode[t], (error_count == errors_before) ? "ok" : "failed");
  endtask

  //////////////////////////////////////////////////
  // Watchdog
  //////////////////////////////////////////////////

  initial begin
    wait (loaded);
    #(elem_in.size() * (2*`NTM_COSH_TERMS + 8) * 4 + test_size_i.size() * 64 + 400);
    $display("Watchdog expired before all tests finished");
    $display("Finished with errors");
    $finish;
  end

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    START = 1'b0;
    DATA_IN_I_ENABLE = 1'b0;
    DATA_IN_J_ENABLE = 1'b0;
    SIZE_IN = '0;
    DATA_IN = '0;
    seed = 32'h984d;
    error_count = 0;
    check_count = 0;
    result_count = 0;
    row_end_count = 0;
    ready_count = 0;
    loaded = 1'b0;
    load_golden();
    loaded = 1'b1;
    // Reset state
    @(negedge CLK);
    while (RST) @(negedge CLK);
    check_count += 4;
    assert (READY == 1'b0) else begin
      $display("ERROR READY expected %h got %h", 1'b0, READY);
      error_count++;
    end
    assert (DATA_OUT_I_ENABLE == 1'b0) else begin
      $display("ERROR DATA_OUT_I_ENABLE expected %h got %h", 1'b0, DATA_OUT_I_ENABLE);
      error_count++;
    end
    assert (DATA_OUT_J_ENABLE == 1'b0) else begin
      $display("ERROR DATA_OUT_J_ENABLE expected %h got %h", 1'b0, DATA_OUT_J_ENABLE);
      error_count++;
    end
    assert (DATA_OUT == '0) else begin
      $display("ERROR DATA_OUT expected %h got %h", 32'h0, DATA_OUT);
      error_count++;
    end
    $display("reset check: %s", (error_count == 0) ? "ok" : "failed");
    drive_slot();
    for (int t = 0; t < test_size_i.size(); t++) begin
      run_test(t);
    end
    $display("tests %0d, checks %0d, errors %0d", test_size_i.size() + 1, check_count,
             error_count);
    if (error_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: ntm_cosh.f
+incdir+common
common/ntm_cosh_pkg.sv
logic/ntm_scalar_cosh.sv
logic/ntm_vector_cosh.sv
matrix/ntm_matrix_cosh.sv
verification/ntm_cosh_clock_gen.sv
verification/ntm_cosh_tb.sv

// File: Makefile
# Verilator build and run for the cosh matrix unit

TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = ntm_cosh_tb
FILELIST = ntm_cosh.f
OBJ_DIR  = obj_dir
LOG      = sim.log
PASS_MSG = Finished with no errors

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation failed" && exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: verification/ntm_cosh_golden.txt
# T size_i size_j mode, hex; mode 0 plain, 1 random gaps and stray J strobes, 2 back to back
# E input expected, both signed Q16.16 in hex
T 1 1 0
E 00000000 00010000
T 1 b 0
E 00000000 00010000
E 00004000 0001080A
E FFFFC000 0001080A
E 00008000 000120AB
E FFFF8000 000120AB
E 00010000 00018B05
E FFFF0000 00018B05
E 00018000 00025A35
E FFFE8000 00025A35
E 00020000 0003C318
E FFFE0000 0003C318
T 3 4 0
E 00000000 00010000
E 00004000 0001080A
E 00008000 000120AB
E 00010000 00018B05
E 00018000 00025A35
E 00020000 0003C318
E FFFE0000 0003C318
E FFFE8000 00025A35
E FFFF0000 00018B05
E FFFF8000 000120AB
E FFFFC000 0001080A
E 00010000 00018B05
T 2 3 1
E 00008000 000120AB
E FFFF8000 000120AB
E 00020000 0003C318
E 00004000 0001080A
E 00000000 00010000
E FFFE8000 00025A35
T 2 2 2
E 00010000 00018B05
E FFFE0000 0003C318
E 00018000 00025A35
E 00000000 00010000
